/* rtl/masku_cfg.svh */
`ifndef MASKU_CFG_SVH
`define MASKU_CFG_SVH

// Mask unit configuration

// Number of lanes feeding the mask unit
`define MASKU_NR_LANES 4

// Element width, also the width of one lane word
`define MASKU_ELEN 64

// Result producing units per lane (ALU and FPU)
`define MASKU_NR_FUNITS 2

`endif

/* rtl/masku_pkg.sv */
`include "masku_cfg.svh"

package masku_pkg;

  // ------------------------------
  // Datapath geometry
  // ------------------------------
  localparam int unsigned NR_LANES    = `MASKU_NR_LANES;
  localparam int unsigned ELEN        = `MASKU_ELEN;
  localparam int unsigned ELENB       = ELEN / 8;
  localparam int unsigned DP_WIDTH    = NR_LANES * ELEN;
  localparam int unsigned DP_BYTES    = DP_WIDTH / 8;
  // m and vd, then one slot per result unit
  localparam int unsigned NR_OPERANDS = `MASKU_NR_FUNITS + 2;

  // Operand slot indices within one lane
  localparam int unsigned OPD_M  = 0;
  localparam int unsigned OPD_VD = 1;
  localparam int unsigned OPD_FU = 2;

  typedef logic [ELEN-1:0]     elen_t;
  typedef logic [DP_WIDTH-1:0] beat_t;

  // ------------------------------
  // Encodings
  // ------------------------------
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef enum logic {
    FU_ALU = 1'b0,
    FU_FPU = 1'b1
  } masku_fu_e;

  // Carry ops read v0 as a source, not as a mask
  typedef enum logic {
    OP_CMP   = 1'b0,
    OP_CARRY = 1'b1
  } masku_op_e;

  typedef struct packed {
    masku_op_e  op;
    masku_fu_e  fu;
    logic       vm;         // 1 means unmasked
    vew_e       vsew;       // source element width
    vew_e       eew_vmask;  // width v0 was written with
    logic [8:0] vrf_pnt;    // bit offset of the first result
  } masku_req_t;

  // Operand words delivered by one lane
  typedef struct packed {
    elen_t m;
    elen_t vd;
    elen_t alu;
    elen_t fpu;
  } lane_ops_t;

  // ------------------------------
  // Lane shuffle helpers
  // ------------------------------

  // Sequential byte index to lane-ordered byte index
  function automatic int unsigned shuffle_index(int unsigned byte_idx, vew_e ew);
    int unsigned ewb;
    int unsigned elem;
    int unsigned k;
    ewb  = 1 << int'(ew);
    elem = byte_idx / ewb;
    k    = byte_idx % ewb;
    return (elem % NR_LANES) * ELENB + (elem / NR_LANES) * ewb + k;
  endfunction

  // Lane-ordered byte index back to sequential byte index
  function automatic int unsigned deshuffle_index(int unsigned byte_idx, vew_e ew);
    int unsigned ewb;
    int unsigned lane;
    int unsigned off;
    int unsigned elem;
    ewb  = 1 << int'(ew);
    lane = byte_idx / ELENB;
    off  = byte_idx % ELENB;
    elem = (off / ewb) * NR_LANES + lane;
    return elem * ewb + (off % ewb);
  endfunction

endpackage

/* rtl/spill_register.sv */
`timescale 1ns/1ps

module spill_register #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  T           slot_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] fill_q;
  logic       push;
  logic       pop;

  // Ready only looks at the fill level, so no path from ready_i
  assign ready_o = (fill_q != 2'd2);
  assign valid_o = (fill_q != 2'd0);
  assign data_o  = slot_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      fill_q   <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      // Simultaneous push and pop keeps the level
      if (push && !pop) begin
        fill_q <= fill_q + 2'd1;
      end else if (pop && !push) begin
        fill_q <= fill_q - 2'd1;
      end
    end
  end

  // Payload slots
  always_ff @(posedge clk_i) begin
    if (push) begin
      slot_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

/* rtl/masku_operands.sv */
`timescale 1ns/1ps

module masku_operands (
  input  logic                                                        clk_i,
  input  logic                                                        arst_n_i,
  input  masku_pkg::masku_req_t                                       req_i,
  input  logic [masku_pkg::NR_LANES-1:0][masku_pkg::NR_OPERANDS-1:0] operand_valid_i,
  output logic [masku_pkg::NR_LANES-1:0][masku_pkg::NR_OPERANDS-1:0] operand_ready_o,
  input  masku_pkg::lane_ops_t [masku_pkg::NR_LANES-1:0]             operands_i,
  input  logic                                                        beat_ready_i,
  output logic                                                        beat_valid_o,
  output masku_pkg::beat_t                                            vd_seq_o,
  output masku_pkg::beat_t                                            alu_compressed_o,
  output masku_pkg::beat_t                                            bit_enable_o
);

  import masku_pkg::*;

  beat_t       alu_beat;
  beat_t       vd_beat_d;
  beat_t       vd_beat_q;
  beat_t       m_beat_d;
  beat_t       m_beat_q;
  beat_t       m_seq;
  int unsigned fu_slot;
  logic        alu_valid;
  logic        vd_lane_valid;
  logic        vd_lane_ready;
  logic        vd_spill_valid;
  logic        m_lane_valid;
  logic        m_lane_ready;
  logic        m_spill_valid;
  logic        beat_pop;

  // ------------------------------
  // Lane gather and handshake
  // ------------------------------
  assign fu_slot = OPD_FU + int'(req_i.fu);

  always_comb begin
    alu_valid     = 1'b1;
    vd_lane_valid = 1'b1;
    m_lane_valid  = 1'b1;
    for (int unsigned lane = 0; lane < NR_LANES; lane++) begin
      alu_beat[ELEN*lane +: ELEN]  = (req_i.fu == FU_FPU) ? operands_i[lane].fpu
                                                           : operands_i[lane].alu;
      vd_beat_d[ELEN*lane +: ELEN] = operands_i[lane].vd;
      m_beat_d[ELEN*lane +: ELEN]  = operands_i[lane].m;
      alu_valid     &= operand_valid_i[lane][fu_slot];
      vd_lane_valid &= operand_valid_i[lane][OPD_VD];
      m_lane_valid  &= operand_valid_i[lane][OPD_M];
    end
  end

  assign beat_valid_o = alu_valid & vd_spill_valid & m_spill_valid;
  assign beat_pop     = beat_valid_o & beat_ready_i;

  // Unselected unit stays at zero
  // vd and m are taken from all lanes at once, so ready waits for every lane
  always_comb begin
    operand_ready_o = '0;
    for (int unsigned lane = 0; lane < NR_LANES; lane++) begin
      operand_ready_o[lane][OPD_M]   = m_lane_valid & m_lane_ready;
      operand_ready_o[lane][OPD_VD]  = vd_lane_valid & vd_lane_ready;
      operand_ready_o[lane][fu_slot] = beat_pop;
    end
  end

  spill_register #(
    .T (beat_t)
  ) i_spill_vd (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (vd_lane_valid),
    .ready_o  (vd_lane_ready),
    .data_i   (vd_beat_d),
    .valid_o  (vd_spill_valid),
    .ready_i  (beat_pop),
    .data_o   (vd_beat_q)
  );

  spill_register #(
    .T (beat_t)
  ) i_spill_m (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (m_lane_valid),
    .ready_o  (m_lane_ready),
    .data_i   (m_beat_d),
    .valid_o  (m_spill_valid),
    .ready_i  (beat_pop),
    .data_o   (m_beat_q)
  );

  // ------------------------------
  // Deshuffle vd and v0
  // ------------------------------
  // v0 may have been written at another width than the source
  always_comb begin
    vd_seq_o = '0;
    m_seq    = '0;
    for (int unsigned b = 0; b < DP_BYTES; b++) begin
      vd_seq_o[8*deshuffle_index(b, req_i.vsew) +: 8]   = vd_beat_q[8*b +: 8];
      m_seq[8*deshuffle_index(b, req_i.eew_vmask) +: 8] = m_beat_q[8*b +: 8];
    end
  end

  // ------------------------------
  // Compression and bit enable
  // ------------------------------
  // LSB of each element lands at vrf_pnt plus its sequential index
  always_comb begin
    int unsigned nr_elems;
    int unsigned src_byte;
    int unsigned dst_bit;
    nr_elems         = DP_BYTES >> req_i.vsew;
    src_byte         = 0;
    dst_bit          = 0;
    alu_compressed_o = '0;
    for (int unsigned i = 0; i < DP_BYTES; i++) begin
      if (i < nr_elems) begin
        src_byte = shuffle_index(i << req_i.vsew, req_i.vsew);
        dst_bit  = i + int'(req_i.vrf_pnt);
        if (dst_bit < DP_WIDTH) begin
          alu_compressed_o[dst_bit] = alu_beat[8*src_byte];
        end
      end
    end
  end

  // Window bits are enabled unless masked off by v0
  always_comb begin
    int unsigned nr_elems;
    int unsigned pnt;
    nr_elems     = DP_BYTES >> req_i.vsew;
    pnt          = req_i.vrf_pnt;
    bit_enable_o = '0;
    for (int unsigned j = 0; j < DP_WIDTH; j++) begin
      if (j >= pnt && j < pnt + nr_elems) begin
        bit_enable_o[j] = req_i.vm || (req_i.op == OP_CARRY) || m_seq[j - pnt];
      end
    end
  end

endmodule

/* rtl/masku_result.sv */
`timescale 1ns/1ps

module masku_result (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             beat_valid_i,
  output logic             beat_ready_o,
  input  masku_pkg::beat_t vd_seq_i,
  input  masku_pkg::beat_t alu_compressed_i,
  input  masku_pkg::beat_t bit_enable_i,
  output masku_pkg::beat_t result_o,
  output logic             result_valid_o,
  input  logic             result_ready_i
);

  import masku_pkg::*;

  beat_t merged;
  beat_t result_q;
  logic  valid_q;
  logic  accept;

  // ------------------------------
  // Merge
  // ------------------------------
  // Disabled bits keep vd, so tail and masked-off bits stay undisturbed
  assign merged = (alu_compressed_i & bit_enable_i) | (vd_seq_i & ~bit_enable_i);

  // ------------------------------
  // Output register
  // ------------------------------
  // Free slot, or the held word leaves this cycle
  assign beat_ready_o = ~valid_q | result_ready_i;
  assign accept       = beat_valid_i & beat_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      if (accept) begin
        valid_q <= 1'b1;
      end else if (result_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      result_q <= merged;
    end
  end

  assign result_o       = result_q;
  assign result_valid_o = valid_q;

endmodule

/* rtl/masku_top.sv */
`timescale 1ns/1ps

module masku_top (
  input  logic                                                        clk_i,
  input  logic                                                        arst_n_i,
  input  masku_pkg::masku_req_t                                       req_i,
  input  logic [masku_pkg::NR_LANES-1:0][masku_pkg::NR_OPERANDS-1:0] operand_valid_i,
  output logic [masku_pkg::NR_LANES-1:0][masku_pkg::NR_OPERANDS-1:0] operand_ready_o,
  input  masku_pkg::lane_ops_t [masku_pkg::NR_LANES-1:0]             operands_i,
  output masku_pkg::beat_t                                            result_o,
  output logic                                                        result_valid_o,
  input  logic                                                        result_ready_i
);

  import masku_pkg::*;

  // Operand stage to result stage
  logic  beat_valid;
  logic  beat_ready;
  beat_t vd_seq;
  beat_t alu_compressed;
  beat_t bit_enable;

  masku_operands i_operands (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .req_i            (req_i),
    .operand_valid_i  (operand_valid_i),
    .operand_ready_o  (operand_ready_o),
    .operands_i       (operands_i),
    .beat_ready_i     (beat_ready),
    .beat_valid_o     (beat_valid),
    .vd_seq_o         (vd_seq),
    .alu_compressed_o (alu_compressed),
    .bit_enable_o     (bit_enable)
  );

  masku_result i_result (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .beat_valid_i     (beat_valid),
    .beat_ready_o     (beat_ready),
    .vd_seq_i         (vd_seq),
    .alu_compressed_i (alu_compressed),
    .bit_enable_i     (bit_enable),
    .result_o         (result_o),
    .result_valid_o   (result_valid_o),
    .result_ready_i   (result_ready_i)
  );

endmodule

/* testbench/masku_properties.sv */
`timescale 1ns/1ps

module masku_properties (
  input logic                                                        clk_i,
  input logic                                                        arst_n_i,
  input masku_pkg::masku_req_t                                       req_i,
  input logic [masku_pkg::NR_LANES-1:0][masku_pkg::NR_OPERANDS-1:0] operand_ready_o,
  input masku_pkg::beat_t                                            result_o,
  input logic                                                        result_valid_o,
  input logic                                                        result_ready_i
);

  import masku_pkg::*;

  int unsigned unsel_slot;

  // Slot of the result unit that the request does not select
  assign unsel_slot = (req_i.fu == FU_FPU) ? OPD_FU : OPD_FU + 1;

  a_result_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    result_valid_o && !result_ready_i |=> $stable(result_o))
    else $error("result_o changed while stalled");

  a_reset_valid: assert property (@(posedge clk_i) $rose(arst_n_i) |-> !result_valid_o)
    else $error("result_valid_o high right after reset");

  for (genvar l = 0; l < NR_LANES; l++) begin : g_lane
    a_unsel_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !operand_ready_o[l][unsel_slot])
      else $error("unselected unit ready high on lane %0d", l);
  end

endmodule

bind masku_top masku_properties masku_properties_i (.*);

/* testbench/masku_tb.sv */
`timescale 1ns/1ps

module masku_tb #(
  parameter int SEED = 73
);

  import masku_pkg::*;

  localparam int NR_TESTS   = 7;
  localparam int REC_WORDS  = 6;
  localparam int CLK_PERIOD = 8;

  logic                                      clk;
  logic                                      arst_n;
  masku_req_t                                req;
  logic [NR_LANES-1:0][NR_OPERANDS-1:0]      operand_valid;
  logic [NR_LANES-1:0][NR_OPERANDS-1:0]      operand_ready;
  lane_ops_t [NR_LANES-1:0]                  operands;
  beat_t                                     result;
  logic                                      result_valid;
  logic                                      result_ready;
  logic [DP_WIDTH-1:0]                       golden [NR_TESTS*REC_WORDS];
  integer                                    seed;
  int                                        pass_cnt;
  int                                        fail_cnt;

  masku_top masku_top_i (
    .clk_i           (clk),
    .arst_n_i        (arst_n),
    .req_i           (req),
    .operand_valid_i (operand_valid),
    .operand_ready_o (operand_ready),
    .operands_i      (operands),
    .result_o        (result),
    .result_valid_o  (result_valid),
    .result_ready_i  (result_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  function automatic string test_name(int idx);
    case (idx)
      0:       return "unmasked_ew8";
      1:       return "unmasked_ew16";
      2:       return "unmasked_ew32_bp";
      3:       return "unmasked_ew64_bp";
      4:       return "masked_cmp";
      5:       return "carry_ignores_mask";
      default: return "fpu_pointer";
    endcase
  endfunction

  // ------------------------------
  // Reset state check
  // ------------------------------
  task automatic check_reset_state();
    logic bad;
    bad = 1'b0;
    if (result_valid !== 1'b0) begin
      $display("reset_state: result valid is high after reset");
      bad = 1'b1;
    end
    for (int l = 0; l < NR_LANES; l++) begin
      if (operand_ready[l][OPD_FU +: 2] !== 2'b00) begin
        $display("reset_state: ALU/FPU ready high on lane %0d before any operand", l);
        bad = 1'b1;
      end
    end
    if (bad) begin
      fail_cnt++;
    end else begin
      $display("test reset_state ok");
      pass_cnt++;
    end
  endtask

  // ------------------------------
  // One golden record
  // ------------------------------
  task automatic run_test(int idx);
    beat_t                                ctrl;
    beat_t                                expected;
    beat_t                                actual;
    logic                                 bp;
    logic                                 got;
    int                                   fu_slot;
    int                                   delay [NR_LANES];
    logic [NR_LANES-1:0][NR_OPERANDS-1:0] want;
    logic [NR_LANES-1:0][NR_OPERANDS-1:0] sent;
    ctrl     = golden[idx*REC_WORDS];
    expected = golden[idx*REC_WORDS+5];
    req      = ctrl[15:0];
    bp       = ctrl[16];
    fu_slot  = OPD_FU + int'(req.fu);
    want     = '0;
    sent     = '0;
    got      = 1'b0;
    actual   = '0;
    for (int l = 0; l < NR_LANES; l++) begin
      operands[l]       = golden[idx*REC_WORDS+1+l];
      want[l][OPD_M]    = 1'b1;
      want[l][OPD_VD]   = 1'b1;
      want[l][fu_slot]  = 1'b1;
      delay[l]          = bp ? ($random(seed) & 3) : 0;
    end
    while (!got) begin
      for (int l = 0; l < NR_LANES; l++) begin
        for (int s = 0; s < NR_OPERANDS; s++) begin
          operand_valid[l][s] = want[l][s] && !sent[l][s] && (delay[l] == 0);
        end
      end
      result_ready = bp ? (($random(seed) & 1) != 0) : 1'b1;
      @(posedge clk);
      sent = sent | (operand_valid & operand_ready);
      if (result_valid && result_ready) begin
        actual = result;
        got    = 1'b1;
      end
      for (int l = 0; l < NR_LANES; l++) begin
        if (delay[l] > 0) begin
          delay[l]--;
        end
      end
      @(negedge clk);
    end
    operand_valid = '0;
    result_ready  = 1'b0;
    if (actual !== expected) begin
      $display("** Error test %s: expected %h, actual %h", test_name(idx), expected, actual);
      fail_cnt++;
    end else begin
      $display("test %s ok", test_name(idx));
      pass_cnt++;
    end
  endtask

  initial begin
    seed          = SEED;
    pass_cnt      = 0;
    fail_cnt      = 0;
    arst_n        = 1'b0;
    req           = '0;
    operand_valid = '0;
    operands      = '0;
    result_ready  = 1'b0;
    $readmemh("testbench/masku_golden.hex", golden);
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    check_reset_state();
    for (int t = 0; t < NR_TESTS; t++) begin
      run_test(t);
    end
    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog, 64 cycles per test plus reset
  initial begin
    repeat (NR_TESTS * 64 + 8) @(posedge clk);
    $display("watchdog: the tests did not finish in time");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* testbench/masku_golden.hex */
// Per test: control {bp flag[16], req[15:0]}, lane 0..3 operands {m, vd, alu, fpu},
// then the expected result word
2000
000000000000000FF0F0F0F0F0F0F0F001010101010101010101010101010101
00000000000000F0F0F0F0F0F0F0F0F000000000000000000101010101010101
0000000000000000F0F0F0F0F0F0F0F001010101010101010101010101010101
0000000000000000F0F0F0F0F0F0F0F000000000000000000101010101010101
F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F055555555
2800
000000000000000FF0F0F0F0F0F0F0F001010101010101010101010101010101
00000000000000F0F0F0F0F0F0F0F0F000000000000000000101010101010101
0000000000000000F0F0F0F0F0F0F0F001010101010101010101010101010101
0000000000000000F0F0F0F0F0F0F0F000000000000000000101010101010101
F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F05555
13000
000000000000000FF0F0F0F0F0F0F0F001010101010101010101010101010101
00000000000000F0F0F0F0F0F0F0F0F000000000000000000101010101010101
0000000000000000F0F0F0F0F0F0F0F001010101010101010101010101010101
0000000000000000F0F0F0F0F0F0F0F000000000000000000101010101010101
F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F055
13800
000000000000000FF0F0F0F0F0F0F0F001010101010101010101010101010101
00000000000000F0F0F0F0F0F0F0F0F000000000000000000101010101010101
0000000000000000F0F0F0F0F0F0F0F001010101010101010101010101010101
0000000000000000F0F0F0F0F0F0F0F000000000000000000101010101010101
F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F5
10800
000000000000000FF0F0F0F0F0F0F0F001010101010101010101010101010101
00000000000000F0F0F0F0F0F0F0F0F000000000000000000101010101010101
0000000000000000F0F0F0F0F0F0F0F001010101010101010101010101010101
0000000000000000F0F0F0F0F0F0F0F000000000000000000101010101010101
F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F050F5
19000
000000000000000FF0F0F0F0F0F0F0F001010101010101010101010101010101
00000000000000F0F0F0F0F0F0F0F0F000000000000000000101010101010101
0000000000000000F0F0F0F0F0F0F0F001010101010101010101010101010101
0000000000000000F0F0F0F0F0F0F0F000000000000000000101010101010101
F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F055
17862
000000000000000FF0F0F0F0F0F0F0F001010101010101010101010101010101
00000000000000F0F0F0F0F0F0F0F0F000000000000000000101010101010101
0000000000000000F0F0F0F0F0F0F0F001010101010101010101010101010101
0000000000000000F0F0F0F0F0F0F0F000000000000000000101010101010101
F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0FCF0F0F0F0F0F0F0F0F0F0F0F0

/* src.f */
+incdir+rtl
rtl/masku_pkg.sv
rtl/spill_register.sv
rtl/masku_operands.sv
rtl/masku_result.sv
rtl/masku_top.sv
testbench/masku_properties.sv
testbench/masku_tb.sv

/* Makefile */
# Verilator flow for the mask unit testbench

VERILATOR ?= verilator
TOP       ?= masku_tb
SEED      ?= 73
OBJ_DIR   ?= obj_dir
FLAGS     ?= --assert --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -GSEED=$(SEED) -f src.f --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -GSEED=$(SEED) -f src.f --top-module $(TOP) \
		--Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
